// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= div_mult_unit_tb
FILELIST  ?= sim.f
OBJDIR    := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove $(OBJDIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJDIR)

// ==== rtl/alu.sv ====
`default_nettype none

module alu
#(
	parameter int WIDTH = 16
)
(
	input  wire lc3b_types::lc3b_aluop aluop,
	input  wire logic [WIDTH-1:0]      a,
	input  wire logic [WIDTH-1:0]      b,
	output logic [WIDTH-1:0]           f
);

	logic [3:0] shamt;

	assign shamt = b[3:0]; // only the low nibble sets the shift distance

	always_comb
	begin
		case (aluop)
			lc3b_types::alu_add:
				f = a + b;
			lc3b_types::alu_and:
				f = a & b;
			lc3b_types::alu_not:
				f = ~a;
			lc3b_types::alu_pass:
				f = a;
			lc3b_types::alu_sll:
				f = a << shamt;
			lc3b_types::alu_srl:
				f = a >> shamt;
			lc3b_types::alu_sra:
				f = $signed(a) >>> shamt; // sign bit fills from the left
			default:
				f = a; // mult and div come from the iterative path
		endcase
	end

endmodule : alu

`default_nettype wire

// ==== rtl/div_mult_unit.sv ====
`default_nettype none

module div_mult_unit
#(
	parameter int WIDTH = 16 // 4 or more
)
(
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire logic [WIDTH-1:0]      sr1,
	input  wire logic [WIDTH-1:0]      sr2,
	input  wire lc3b_types::lc3b_aluop aluop,
	output logic [WIDTH-1:0]           solution,
	output logic                       stall_X
);

	logic [WIDTH-1:0] alu_f;
	logic [WIDTH-1:0] product_quotient;
	logic             start;
	logic             step;
	logic             is_div;
	logic             muldiv_sel;
	logic             last;

	alu #(
		.WIDTH (WIDTH)
	) u_alu (
		.aluop (aluop),
		.a     (sr1),
		.b     (sr2),
		.f     (alu_f)
	);

	muldiv_control u_control (
		.clk        (clk),
		.rst        (rst),
		.aluop      (aluop),
		.last       (last),
		.start      (start),
		.step       (step),
		.is_div     (is_div),
		.muldiv_sel (muldiv_sel),
		.stall_X    (stall_X)
	);

	step_counter #(
		.WIDTH (WIDTH)
	) u_counter (
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.step  (step),
		.last  (last)
	);

	muldiv_datapath #(
		.WIDTH (WIDTH)
	) u_datapath (
		.clk              (clk),
		.rst              (rst),
		.start            (start),
		.step             (step),
		.is_div           (is_div),
		.sr1              (sr1),
		.sr2              (sr2),
		.product_quotient (product_quotient)
	);

	// iterative result while running and in the release cycle, alu otherwise
	assign solution = muldiv_sel ? product_quotient : alu_f;

endmodule : div_mult_unit

`default_nettype wire

// ==== rtl/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

	// execute-stage opcodes, shared by the alu and the iterative unit
	typedef enum logic [3:0]
	{
		alu_add,  // a + b
		alu_and,  // a & b
		alu_not,  // ~a
		alu_pass, // a
		alu_sll,  // logical left shift by b[3:0]
		alu_srl,  // logical right shift by b[3:0]
		alu_sra,  // arithmetic right shift by b[3:0]
		alu_mult, // unsigned multiply, low half kept
		alu_div   // unsigned divide, quotient only
	} lc3b_aluop;

	// multiply / divide sequencing
	typedef enum logic [1:0]
	{
		st_idle, // waiting for a mult or div opcode
		st_run,  // one iteration per cycle
		st_done  // result valid, stall released
	} muldiv_state;

endpackage : lc3b_types

`default_nettype wire

// ==== rtl/muldiv_control.sv ====
`default_nettype none

module muldiv_control
(
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire lc3b_types::lc3b_aluop aluop,
	input  wire logic                  last,
	output logic                       start,
	output logic                       step,
	output logic                       is_div,
	output logic                       muldiv_sel,
	output logic                       stall_X
);

	lc3b_types::muldiv_state state_q;
	lc3b_types::muldiv_state state_d;
	logic                    is_md;

	assign is_md = (aluop == lc3b_types::alu_mult) || (aluop == lc3b_types::alu_div);

	// next state
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			lc3b_types::st_idle:
			begin
				if (is_md)
				begin
					state_d = lc3b_types::st_run;
				end
			end
			lc3b_types::st_run:
			begin
				if (last)
				begin
					state_d = lc3b_types::st_done;
				end
			end
			lc3b_types::st_done:
			begin
				state_d = lc3b_types::st_idle; // pipeline advances on this edge
			end
			default:
			begin
				state_d = lc3b_types::st_idle;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= lc3b_types::st_idle;
			is_div  <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			if (start)
			begin
				is_div <= (aluop == lc3b_types::alu_div); // held for the whole operation
			end
		end
	end

	assign start      = (state_q == lc3b_types::st_idle) && is_md;
	assign step       = (state_q == lc3b_types::st_run);
	assign muldiv_sel = (state_q == lc3b_types::st_run) || (state_q == lc3b_types::st_done);
	assign stall_X    = start || step; // WIDTH+1 cycles per operation

	// the stage must be free to advance once the result is shown
	a_no_stall_in_done: assert property (@(posedge clk) disable iff (rst)
		(state_q == lc3b_types::st_done) |-> !stall_X);

	// the counter may only finish while iterating
	a_last_in_run: assert property (@(posedge clk) disable iff (rst)
		last |-> (state_q == lc3b_types::st_run));

	// loading and iterating never overlap
	a_start_step_excl: assert property (@(posedge clk) disable iff (rst)
		!(start && step));

endmodule : muldiv_control

`default_nettype wire

// ==== rtl/muldiv_datapath.sv ====
`default_nettype none

module muldiv_datapath
#(
	parameter int WIDTH = 16
)
(
	input  wire logic             clk,
	input  wire logic             rst,
	input  wire logic             start,
	input  wire logic             step,
	input  wire logic             is_div,
	input  wire logic [WIDTH-1:0] sr1,
	input  wire logic [WIDTH-1:0] sr2,
	output logic [WIDTH-1:0]      product_quotient
);

	logic [WIDTH-1:0] op_q;    // multiplicand or divisor
	logic [WIDTH-1:0] shift_q; // multiplier, or dividend out / quotient in
	logic [WIDTH-1:0] acc_q;   // product or partial remainder

	logic [WIDTH-1:0] mul_sum;
	logic [WIDTH:0]   rem_shift;
	logic [WIDTH+1:0] rem_diff;
	logic             q_bit;

	// multiply: add the shifted multiplicand when the multiplier lsb is set
	assign mul_sum = shift_q[0] ? (acc_q + op_q) : acc_q;

	// divide: bring down the next dividend bit and trial-subtract
	assign rem_shift = {acc_q, shift_q[WIDTH-1]};
	assign rem_diff  = {1'b0, rem_shift} - {2'b00, op_q};
	assign q_bit     = ~rem_diff[WIDTH+1]; // no borrow means the divisor fits

	// operand and shift registers
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			op_q    <= sr2;
			shift_q <= sr1;
		end
		else if (step)
		begin
			if (is_div)
			begin
				shift_q <= {shift_q[WIDTH-2:0], q_bit}; // quotient fills from the right
			end
			else
			begin
				op_q    <= op_q << 1;
				shift_q <= shift_q >> 1;
			end
		end
	end

	// accumulator / partial remainder
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acc_q <= '0;
		end
		else if (start)
		begin
			acc_q <= '0;
		end
		else if (step)
		begin
			if (is_div)
			begin
				// restore by keeping the shifted value when the subtract borrows
				acc_q <= q_bit ? rem_diff[WIDTH-1:0] : rem_shift[WIDTH-1:0];
			end
			else
			begin
				acc_q <= mul_sum;
			end
		end
	end

	// a zero divisor never borrows, so the quotient comes out all ones
	assign product_quotient = is_div ? shift_q : acc_q;

endmodule : muldiv_datapath

`default_nettype wire

// ==== rtl/step_counter.sv ====
`default_nettype none

module step_counter
#(
	parameter int WIDTH = 16
)
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic start,
	input  wire logic step,
	output logic      last
);

	localparam int CW = $clog2(WIDTH); // holds WIDTH-1

	logic [CW-1:0] count_q;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count_q <= '0;
		end
		else if (start)
		begin
			count_q <= CW'(WIDTH - 1); // one step per operand bit
		end
		else if (step && (count_q != '0))
		begin
			count_q <= count_q - 1'b1;
		end
	end

	assign last = step && (count_q == '0);

	// once exhausted, no further step may come before the next start
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		last |=> !step);

endmodule : step_counter

`default_nettype wire

// ==== sim.f ====
rtl/lc3b_types.sv
rtl/alu.sv
rtl/step_counter.sv
rtl/muldiv_datapath.sv
rtl/muldiv_control.sv
rtl/div_mult_unit.sv
sim/div_mult_unit_tb.sv

// ==== sim/div_mult_unit_tb.sv ====
`default_nettype none

module div_mult_unit_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WIDTH        = 16;
	localparam int STALL_CYCLES = WIDTH + 1; // start cycle plus one per bit
	localparam int NUM_DIRECTED = 25;
	localparam int NUM_RANDOM   = 16;
	localparam int NUM_ENTRIES  = NUM_DIRECTED + NUM_RANDOM;
	localparam int MAX_CYCLES   = NUM_ENTRIES * 20 + 50;

	logic                  clk = 1'b0;
	logic                  rst;
	logic [WIDTH-1:0]      sr1;
	logic [WIDTH-1:0]      sr2;
	lc3b_types::lc3b_aluop aluop;
	logic [WIDTH-1:0]      solution;
	logic                  stall_X;

	// stimulus table
	lc3b_types::lc3b_aluop op_tab  [NUM_ENTRIES];
	logic [WIDTH-1:0]      a_tab   [NUM_ENTRIES];
	logic [WIDTH-1:0]      b_tab   [NUM_ENTRIES];
	logic [WIDTH-1:0]      exp_tab [NUM_ENTRIES];

	int n_entries      = 0;
	int error_count    = 0;
	int entries_passed = 0;
	int entries_failed = 0;
	int cycle_count    = 0;

	div_mult_unit #(
		.WIDTH (WIDTH)
	) DUT (
		.clk      (clk),
		.rst      (rst),
		.sr1      (sr1),
		.sr2      (sr2),
		.aluop    (aluop),
		.solution (solution),
		.stall_X  (stall_X)
	);

	always #20 clk = ~clk; // 40 ns period

	// run limit sized from the table length
	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("run timed out after %0d cycles waiting for stall_X to drop", cycle_count);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp)
		begin
			$display("error at %0t: %s, got %h expected %h", $time, msg, got, exp);
			error_count++;
		end
	endtask

	task automatic add_entry(input lc3b_types::lc3b_aluop op, input logic [WIDTH-1:0] a,
		input logic [WIDTH-1:0] b, input logic [WIDTH-1:0] exp);
		op_tab[n_entries]  = op;
		a_tab[n_entries]   = a;
		b_tab[n_entries]   = b;
		exp_tab[n_entries] = exp;
		n_entries++;
	endtask

	task automatic build_table();
		logic [WIDTH-1:0]   a;
		logic [WIDTH-1:0]   b;
		logic [WIDTH-1:0]   quot;
		logic [2*WIDTH-1:0] prod;
		add_entry(lc3b_types::alu_add,  16'h1234, 16'h4321, 16'h5555);
		add_entry(lc3b_types::alu_add,  16'hFFFF, 16'h0001, 16'h0000); // wraps
		add_entry(lc3b_types::alu_and,  16'hF0F0, 16'h3C3C, 16'h3030);
		add_entry(lc3b_types::alu_not,  16'h00FF, 16'h1111, 16'hFF00);
		add_entry(lc3b_types::alu_pass, 16'hBEEF, 16'h1234, 16'hBEEF);
		add_entry(lc3b_types::alu_sll,  16'h0001, 16'h000F, 16'h8000);
		add_entry(lc3b_types::alu_sll,  16'h1234, 16'h0000, 16'h1234);
		add_entry(lc3b_types::alu_sll,  16'h00F1, 16'h00F3, 16'h0788); // upper bits of b ignored
		add_entry(lc3b_types::alu_srl,  16'h8000, 16'h000F, 16'h0001);
		add_entry(lc3b_types::alu_srl,  16'hF0F0, 16'h0004, 16'h0F0F);
		add_entry(lc3b_types::alu_sra,  16'h8000, 16'h0004, 16'hF800);
		add_entry(lc3b_types::alu_sra,  16'hF0F0, 16'h000F, 16'hFFFF);
		add_entry(lc3b_types::alu_sra,  16'h7FF0, 16'h0004, 16'h07FF);
		add_entry(lc3b_types::alu_sra,  16'h9234, 16'h0000, 16'h9234);
		add_entry(lc3b_types::alu_mult, 16'h0000, 16'h1234, 16'h0000);
		add_entry(lc3b_types::alu_mult, 16'h0001, 16'hABCD, 16'hABCD);
		add_entry(lc3b_types::alu_mult, 16'hFFFF, 16'hFFFF, 16'h0001);
		add_entry(lc3b_types::alu_mult, 16'h0123, 16'h0045, 16'h4E6F);
		add_entry(lc3b_types::alu_div,  16'h1234, 16'h0000, 16'hFFFF); // zero divisor
		add_entry(lc3b_types::alu_div,  16'hFFFF, 16'h0001, 16'hFFFF);
		add_entry(lc3b_types::alu_div,  16'h0064, 16'h0007, 16'h000E);
		add_entry(lc3b_types::alu_add,  16'h0003, 16'h0004, 16'h0007); // right after a divide
		add_entry(lc3b_types::alu_div,  16'h0005, 16'h0009, 16'h0000);
		add_entry(lc3b_types::alu_div,  16'hFFFF, 16'hFFFF, 16'h0001);
		add_entry(lc3b_types::alu_mult, 16'h0100, 16'h0100, 16'h0000);
		for (int i = 0; i < NUM_RANDOM / 2; i++)
		begin
			a    = WIDTH'($urandom);
			b    = WIDTH'($urandom);
			prod = (2*WIDTH)'(a) * (2*WIDTH)'(b);
			add_entry(lc3b_types::alu_mult, a, b, prod[WIDTH-1:0]);
			a = WIDTH'($urandom);
			if (i % 2 == 0)
				b = WIDTH'($urandom % 256); // small divisors give larger quotients
			else
				b = WIDTH'($urandom);
			if (b == '0)
				quot = '1;
			else
				quot = a / b;
			add_entry(lc3b_types::alu_div, a, b, quot);
		end
	endtask

	// entered and left on a falling edge
	task automatic apply_entry(input int idx);
		int  stalls;
		int  err_before;
		bit  multi;
		bit  after_multi;
		err_before  = error_count;
		multi       = (op_tab[idx] == lc3b_types::alu_mult) || (op_tab[idx] == lc3b_types::alu_div);
		after_multi = (idx > 0) && ((op_tab[idx-1] == lc3b_types::alu_mult) ||
			(op_tab[idx-1] == lc3b_types::alu_div));
		aluop       = op_tab[idx];
		sr1         = a_tab[idx];
		sr2         = b_tab[idx];
		stalls      = 0;
		if (multi)
		begin
			#1;
			// a new op given during the done cycle only starts one cycle later
			check_value(32'(stall_X), 32'(!after_multi), "stall_X in issue cycle");
			if (stall_X)
				stalls = 1;
			@(negedge clk);
			while (stall_X)
			begin
				stalls++;
				@(negedge clk);
			end
			check_value(32'(solution), 32'(exp_tab[idx]), "iterative result");
			check_value(32'(stalls), 32'(STALL_CYCLES), "stall cycle count");
		end
		else
		begin
			@(negedge clk);
			check_value(32'(solution), 32'(exp_tab[idx]), "single-cycle result");
			check_value(32'(stall_X), 32'(0), "stall_X on single-cycle op");
		end
		if (error_count == err_before)
			entries_passed++;
		else
			entries_failed++;
		$display("entry %0d %s sr1=%h sr2=%h solution=%h expected=%h stalls=%0d %s", idx,
			op_tab[idx].name(), a_tab[idx], b_tab[idx], solution, exp_tab[idx], stalls,
			(error_count == err_before) ? "ok" : "mismatch");
	endtask

	initial
	begin
		int err_before;
		void'($urandom(64));
		rst   = 1'b1;
		aluop = lc3b_types::alu_add;
		sr1   = 16'h1234;
		sr2   = 16'h0101;
		build_table();
		repeat (4) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		err_before = error_count;
		check_value(32'(stall_X), 32'(0), "stall_X after reset");
		check_value(32'(solution), 32'h1335, "add after reset");
		if (error_count == err_before)
			entries_passed++;
		else
			entries_failed++;
		$display("after reset add solution=%h stall_X=%b %s", solution, stall_X,
			(error_count == err_before) ? "ok" : "mismatch");
		for (int idx = 0; idx < n_entries; idx++)
		begin
			apply_entry(idx);
		end
		$display("%0d tests run, %0d passed, %0d failed", entries_passed + entries_failed,
			entries_passed, entries_failed);
		if (entries_failed == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire
